// File: compile.f
+incdir+logic
logic/vtPkg.sv
logic/pixelCenGen.sv
logic/rasterTiming.sv
logic/apbVideoRegs.sv
logic/testPattern.sv
logic/videoTimingTop.sv
test/tbClock.sv
test/videoTiming_properties.sv
test/videoTimingTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := videoTimingTb
FILELIST  := compile.f
BUILD_DIR := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: test/videoTimingTb.sv
`default_nettype none

`include "vtConsts.svh"

module videoTimingTb import vtPkg::*; ;

    localparam int LineClks   = int'(`VT_LINE_LAST) + 1;                 // 384.
    localparam int BlankClks  = LineClks - (int'(`VT_ACTIVE_LAST) + 1);   // 128.
    localparam int FrameLines = int'(`VT_V_LAST) - int'(`VT_V_FIRST) + 1;
    localparam int VblLines   = int'(`VT_V_LAST) - int'(`VT_VBL_START) + 1;
    localparam int FrameClks  = LineClks * FrameLines;
    // Two frames at div 0 plus one at div 3 and two for the pattern runs.
    localparam int WatchdogClks = (2 + 4 + 2) * FrameClks;
    localparam int SelHBlank = 0;
    localparam int SelVSync  = 1;

    logic        clk;
    logic        rstN;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        hSync;
    logic        vSync;
    logic        hBlank;
    logic        vBlank;
    logic [11:0] rgb;
    logic [5:0]  busPhase;
    logic        irq;
    int          errCount;
    int          testCount;
    int          failedTests;

    tbClock i_clk (.clk(clk));

    videoTimingTop i_dut (
        .clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .hSync(hSync), .vSync(vSync), .hBlank(hBlank), .vBlank(vBlank),
        .rgb(rgb), .busPhase(busPhase), .irq(irq)
    );

    bind rasterTiming videoTiming_properties i_props (
        .clk(clk), .rstN(rstN), .pxlCen(pxlCen), .hPos(hPos),
        .hBlank(hBlank), .vBlank(vBlank), .hSync(hSync), .vSync(vSync),
        .busPhase(busPhase)
    );

    // ************************************************************
    // Helpers.
    // ************************************************************

    task automatic showMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        errCount++;
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        testCount++;
        if (errCount == errsBefore) begin
            $display("%s: ok", name);
        end else begin
            failedTests++;
            $display("%s: %0d errors", name, errCount - errsBefore);
        end
    endtask

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;        // Setup.
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;        // Access.
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbRead(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;          // Combinational in access phase.
        if (pready !== 1'b1) showMismatch("pready", 32'(pready), 32'd1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic logic pickSignal(input int sel);
        return (sel == SelHBlank) ? hBlank : vSync;
    endfunction

    // Waits at negedges until the chosen signal reaches level.
    task automatic waitEdge(input int sel, input logic level);
        logic prev;
        @(negedge clk);
        prev = pickSignal(sel);
        while (1) begin
            @(negedge clk);
            if ((pickSignal(sel) == level) && (prev != level)) break;
            prev = pickSignal(sel);
        end
    endtask

    // Clocks from one hBlank rise to the next.
    task automatic measureLine(output int period, output int blank, output int syncs);
        logic prev;
        waitEdge(SelHBlank, 1'b1);
        period = 0;
        blank  = 0;
        syncs  = 0;
        prev   = 1'b1;
        while (1) begin
            @(negedge clk);
            period++;
            if (hBlank) blank++;
            if (hSync) syncs++;
            if (hBlank && !prev) break;
            prev = hBlank;
        end
    endtask

    function automatic logic [11:0] expectedColour(input patternMode mode,
            input logic [7:0] hp, input logic [7:0] vp, input logic blanked);
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        r = 4'h0;
        g = 4'h0;
        b = 4'h0;
        case (mode)
            PatBars: begin
                r = hp[7] ? 4'hF : 4'h0;
                g = hp[6] ? 4'hF : 4'h0;
                b = hp[5] ? 4'hF : 4'h0;
            end
            PatGrid: begin
                if ((hp[3:0] == 4'h0) || (vp[3:0] == 4'h0)) begin
                    r = 4'hF;
                    g = 4'hF;
                    b = 4'hF;
                end
            end
            PatRamp: begin
                r = hp[7:4];
                g = vp[7:4];
            end
            default: r = 4'h0;
        endcase
        return blanked ? 12'h000 : {r, g, b};
    endfunction

    // Bus slot strobe for a horizontal count.
    function automatic logic [5:0] phaseForCount(input int count);
        int slot;
        slot = (count / 2) % 8;
        if ((count % 2 == 1) && (slot < 6)) begin
            return 6'(1 << slot);
        end
        return 6'd0;
    endfunction

    // ************************************************************
    // Tests.
    // ************************************************************

    task automatic regAccessTest;
        int          errs;
        logic [31:0] value;
        logic [31:0] rd;
        errs = errCount;
        @(negedge clk);
        if (irq !== 1'b0) showMismatch("irq", 32'(irq), 32'd0);
        if (hBlank !== 1'b0) showMismatch("hBlank", 32'(hBlank), 32'd0);
        if (vBlank !== 1'b0) showMismatch("vBlank", 32'(vBlank), 32'd0);
        if (rgb !== 12'h000) showMismatch("rgb", 32'(rgb), 32'd0);
        for (int i = 0; i < 4; i++) begin
            value = $urandom;
            apbWrite(`VT_ADDR_CTRL, value);
            apbRead(`VT_ADDR_CTRL, rd);
            if (rd !== {24'd0, value[7:0]}) showMismatch("prdata", rd, {24'd0, value[7:0]});
        end
        apbRead(12'h00C, rd);
        if (rd !== 32'd0) showMismatch("prdata", rd, 32'd0);
        apbRead(12'hFFC, rd);
        if (rd !== 32'd0) showMismatch("prdata", rd, 32'd0);
        apbWrite(`VT_ADDR_CTRL, 32'd0);
        reportTest("Register access", errs);
    endtask

    task automatic lineTimingTest;
        int errs;
        int period;
        int blank;
        int syncs;
        errs = errCount;
        apbWrite(`VT_ADDR_CTRL, 32'h1);     // Enable, div 0.
        measureLine(period, blank, syncs);
        if (period != LineClks) showMismatch("line period", period, LineClks);
        if (blank != BlankClks) showMismatch("hBlank clocks", blank, BlankClks);
        if (syncs != 1) showMismatch("hSync clocks", syncs, 1);
        reportTest("Line timing", errs);
    endtask

    task automatic frameTimingTest;
        int          errs;
        int          lines;
        int          vblCount;
        logic        prevH;
        logic        prevVb;
        logic        prevVs;
        logic [31:0] rd;
        errs = errCount;
        waitEdge(SelVSync, 1'b1);
        apbWrite(`VT_ADDR_IRQ, 32'h1);      // Drop the flag from this blank.
        @(negedge clk);
        if (irq !== 1'b0) showMismatch("irq", 32'(irq), 32'd0);
        lines    = 0;
        vblCount = 0;
        prevH    = hBlank;
        prevVb   = vBlank;
        prevVs   = vSync;
        while (1) begin
            @(negedge clk);
            if (vSync && !prevVs) break;
            if (hBlank && !prevH) begin
                lines++;
                if (vBlank) vblCount++;
            end
            if (vBlank && !prevVb) begin
                if (irq !== 1'b0) showMismatch("irq", 32'(irq), 32'd0);
                @(negedge clk);
                if (irq !== 1'b1) showMismatch("irq", 32'(irq), 32'd1);
            end
            prevH  = hBlank;
            prevVb = vBlank;
            prevVs = vSync;
        end
        if (lines != FrameLines) showMismatch("lines per frame", lines, FrameLines);
        if (vblCount != VblLines) showMismatch("vBlank lines", vblCount, VblLines);
        apbRead(`VT_ADDR_STATUS, rd);
        if (rd !== {16'd0, `VT_VS_LINE, 8'h01}) begin
            showMismatch("prdata", rd, {16'd0, `VT_VS_LINE, 8'h01});
        end
        apbRead(`VT_ADDR_IRQ, rd);
        if (rd !== 32'd1) showMismatch("prdata", rd, 32'd1);
        apbWrite(`VT_ADDR_IRQ, 32'h1);
        apbRead(`VT_ADDR_IRQ, rd);
        if (rd !== 32'd0) showMismatch("prdata", rd, 32'd0);
        if (irq !== 1'b0) showMismatch("irq", 32'(irq), 32'd0);
        reportTest("Frame timing and interrupt", errs);
    endtask

    task automatic dividerTest;
        int         errs;
        int         period;
        int         blank;
        int         syncs;
        logic [3:0] d;
        errs = errCount;
        d = 4'(1 + ($urandom % 15));
        apbWrite(`VT_ADDR_CTRL, {24'd0, d, 4'b0001});
        measureLine(period, blank, syncs);  // Discard the line across the change.
        measureLine(period, blank, syncs);
        if (period != LineClks * (d + 1)) showMismatch("line period", period, LineClks * (d + 1));
        if (blank != BlankClks * (d + 1)) showMismatch("hBlank clocks", blank, BlankClks * (d + 1));
        if (syncs != d + 1) showMismatch("hSync clocks", syncs, d + 1);
        reportTest("Pixel divider", errs);
    endtask

    task automatic patternFlipTest;
        int          errs;
        logic [1:0]  d;
        logic [1:0]  mode;
        logic        flip;
        logic [7:0]  mask;
        logic [7:0]  line;
        logic [31:0] rd;
        logic [11:0] exp;
        errs = errCount;
        for (int run = 0; run < 8; run++) begin
            mode = 2'(run >> 1);
            flip = run[0];
            d    = 2'($urandom % 4);
            mask = {8{flip}};
            apbWrite(`VT_ADDR_CTRL, {24'd0, 2'b00, d, mode, flip, 1'b1});
            @(negedge clk);
            while (vBlank) @(negedge clk);
            waitEdge(SelHBlank, 1'b1);
            apbRead(`VT_ADDR_STATUS, rd);
            line = (rd[15:8] == `VT_V_LAST) ? `VT_V_FIRST : rd[15:8] + 8'd1;
            waitEdge(SelHBlank, 1'b0);
            // Pixel k shows after enable k+1 counted from the line start.
            for (int k = 0; k < 256; k++) begin
                repeat (int'(d) + 1) @(negedge clk);
                exp = expectedColour(patternMode'(mode), 8'(k) ^ mask, line ^ mask,
                                     line >= `VT_VBL_START);
                if (rgb !== exp) showMismatch("rgb", 32'(rgb), 32'(exp));
                if (busPhase !== phaseForCount(k + 1)) begin
                    showMismatch("busPhase", 32'(busPhase), 32'(phaseForCount(k + 1)));
                end
            end
        end
        reportTest("Pattern and flip", errs);
    endtask

    // ************************************************************
    // Main sequence and watchdog.
    // ************************************************************

    initial begin
        repeat (WatchdogClks) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WatchdogClks);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(20812));
        errCount    = 0;
        testCount   = 0;
        failedTests = 0;
        rstN    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 12'd0;
        pwdata  = 32'd0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        regAccessTest();
        lineTimingTest();
        frameTimingTest();
        dividerTest();
        patternFlipTest();
        $display("%0d tests run, %0d with errors, %0d errors in all",
                 testCount, failedTests, errCount);
        if (errCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/videoTiming_properties.sv
`default_nettype none

// Timing checks bound into rasterTiming.
module videoTiming_properties (
    input wire logic       clk,
    input wire logic       rstN,
    input wire logic       pxlCen,
    input wire logic [7:0] hPos,
    input wire logic       hBlank,
    input wire logic       vBlank,
    input wire logic       hSync,
    input wire logic       vSync,
    input wire logic [5:0] busPhase
);

    // HS drops on the enable after it rose.
    assert property (@(posedge clk) disable iff (!rstN)
        (hSync && pxlCen) |=> !hSync)
        else $error("HS wider than one pixel");

    // VS moves at line start and hBlank rises mid line.
    assert property (@(posedge clk) disable iff (!rstN)
        !($rose(hBlank) && $changed(vSync)))
        else $error("hBlank rose while vSync changed");

    assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(busPhase))
        else $error("busPhase has more than one bit set");

    // Every timing output updates on an enable edge only.
    assert property (@(posedge clk) disable iff (!rstN)
        $changed({hBlank, vBlank, hSync, vSync, busPhase, hPos}) |-> $past(pxlCen))
        else $error("Timing output changed without a pixel enable");

endmodule

`default_nettype wire

// File: test/tbClock.sv
`default_nettype none

// Free running testbench clock, period 20.
module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;     // Half period.

endmodule

`default_nettype wire

// File: logic/videoTimingTop.sv
`default_nettype none

// Video timing subsystem top.
module videoTimingTop import vtPkg::*; (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [11:0] paddr,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             hSync,
    output logic             vSync,
    output logic             hBlank,
    output logic             vBlank,
    output logic      [11:0] rgb,
    output logic      [5:0]  busPhase,
    output logic             irq
);

    logic       enable;
    logic       flip;
    logic [3:0] pixDiv;
    patternMode patMode;
    logic       pxlCen;     // Shared pixel enable.
    logic [7:0] hPos;
    logic [7:0] vPos;
    logic [7:0] vLine;

    pixelCenGen i_cen (
        .clk    (clk),
        .rstN   (rstN),
        .enable (enable),
        .pixDiv (pixDiv),
        .pxlCen (pxlCen)
    );

    rasterTiming i_timing (
        .clk      (clk),
        .rstN     (rstN),
        .pxlCen   (pxlCen),
        .flip     (flip),
        .hPos     (hPos),
        .vPos     (vPos),
        .vLine    (vLine),
        .hBlank   (hBlank),
        .vBlank   (vBlank),
        .hSync    (hSync),
        .vSync    (vSync),
        .busPhase (busPhase)
    );

    // Software view.
    apbVideoRegs i_regs (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .vBlank  (vBlank),
        .vLine   (vLine),
        .enable  (enable),
        .flip    (flip),
        .pixDiv  (pixDiv),
        .patMode (patMode),
        .irq     (irq)
    );

    testPattern i_pattern (
        .clk     (clk),
        .rstN    (rstN),
        .pxlCen  (pxlCen),
        .hPos    (hPos),
        .vPos    (vPos),
        .hBlank  (hBlank),
        .vBlank  (vBlank),
        .patMode (patMode),
        .rgb     (rgb)
    );

endmodule

`default_nettype wire

// File: logic/testPattern.sv
`default_nettype none

// Test pattern colour, 4 bits per channel, R in the top nibble.
module testPattern import vtPkg::*; (
    input  wire logic       clk,
    input  wire logic       rstN,
    input  wire logic       pxlCen,
    input  wire logic [7:0] hPos,
    input  wire logic [7:0] vPos,
    input  wire logic       hBlank,
    input  wire logic       vBlank,
    input  wire patternMode patMode,
    output logic [11:0]     rgb
);

    logic [11:0] colour;
    logic        gridLine;

    assign gridLine = (hPos[3:0] == 4'd0) || (vPos[3:0] == 4'd0);

    // Colour rule per mode.
    always_comb begin
        case (patMode)
            PatBars:  colour = {{4{hPos[7]}}, {4{hPos[6]}}, {4{hPos[5]}}};  // Eight bars.
            PatGrid:  colour = gridLine ? 12'hFFF : 12'h000;
            PatRamp:  colour = {hPos[7:4], vPos[7:4], 4'h0};
            default:  colour = 12'h000;                                      // Black.
        endcase
    end

    // ************************************************************
    // Pixel register, black outside the active area.
    // ************************************************************

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rgb <= 12'h000;
        end else if (pxlCen) begin
            if (hBlank || vBlank) begin
                rgb <= 12'h000;
            end else begin
                rgb <= colour;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/apbVideoRegs.sv
`default_nettype none

`include "vtConsts.svh"

// APB register block.
// CTRL: bit 0 enable, bit 1 flip, bits 3:2 pattern, bits 7:4 pixel divider.
// STATUS: bit 0 vBlank, bits 15:8 current line.
// IRQ: bit 0 pending, write 1 to clear.
module apbVideoRegs import vtPkg::*; (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [11:0] paddr,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    input  wire logic        vBlank,
    input  wire logic [7:0]  vLine,
    output logic             enable,
    output logic             flip,
    output logic      [3:0]  pixDiv,
    output patternMode       patMode,
    output logic             irq
);

    logic [7:0]  ctrl;
    logic        pending;       // Vertical blank interrupt.
    logic        vBlankD;       // For edge detect.
    logic        wrEn;
    logic        vblRise;
    regIndex     regSel;
    logic [31:0] rdData;

    assign pready = 1'b1;       // No wait states.
    assign wrEn   = psel && penable && pwrite;    // Access phase.
    assign vblRise = vBlank && !vBlankD;

    // Address decode.
    always_comb begin
        case (paddr)
            `VT_ADDR_CTRL:   regSel = RegCtrl;
            `VT_ADDR_STATUS: regSel = RegStatus;
            `VT_ADDR_IRQ:    regSel = RegIrq;
            default:         regSel = RegNone;
        endcase
    end

    // Read mux.
    always_comb begin
        case (regSel)
            RegCtrl:   rdData = {24'd0, ctrl};
            RegStatus: rdData = {16'd0, vLine, 7'd0, vBlank};
            RegIrq:    rdData = {31'd0, pending};
            default:   rdData = 32'd0;
        endcase
    end

    assign prdata = (psel && !pwrite) ? rdData : 32'd0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrl    <= 8'd0;
            pending <= 1'b0;
            vBlankD <= 1'b0;
        end else begin
            vBlankD <= vBlank;
            if (wrEn && (regSel == RegCtrl)) begin
                ctrl <= pwdata[7:0];
            end
            if (vblRise) begin
                pending <= 1'b1;        // Set beats clear.
            end else if (wrEn && (regSel == RegIrq) && pwdata[0]) begin
                pending <= 1'b0;
            end
        end
    end

    // Control fields.
    assign enable  = ctrl[0];
    assign flip    = ctrl[1];
    assign patMode = patternMode'(ctrl[3:2]);
    assign pixDiv  = ctrl[7:4];
    assign irq     = pending;

endmodule

`default_nettype wire

// File: logic/rasterTiming.sv
`default_nettype none

`include "vtConsts.svh"

// Raster counters, blanking, sync and bus phase strobes.
module rasterTiming (
    input  wire logic       clk,
    input  wire logic       rstN,
    input  wire logic       pxlCen,
    input  wire logic       flip,
    output logic [7:0]      hPos,
    output logic [7:0]      vPos,
    output logic [7:0]      vLine,
    output logic            hBlank,
    output logic            vBlank,
    output logic            hSync,
    output logic            vSync,
    output logic [5:0]      busPhase
);

    logic [8:0] hCnt;       // Pixel within line.
    logic [7:0] vCnt;       // Line within frame.
    logic [8:0] nextH;
    logic [7:0] nextV;
    logic       lineEnd;
    logic [5:0] phaseNext;

    // ************************************************************
    // Next count. All outputs derive from it.
    // ************************************************************

    assign lineEnd = (hCnt == `VT_LINE_LAST);
    assign nextH   = lineEnd ? 9'd0 : hCnt + 9'd1;

    // Line steps on the wrap, 0xFF back to first line.
    always_comb begin
        nextV = vCnt;
        if (lineEnd) begin
            if (vCnt == `VT_V_LAST) begin
                nextV = `VT_V_FIRST;
            end else begin
                nextV = vCnt + 8'd1;
            end
        end
    end

    // Video memory slots on odd pixels, six of eight used.
    always_comb begin
        phaseNext = 6'd0;
        if (nextH[0] && (nextH[3:1] < 3'd6)) begin
            phaseNext[nextH[3:1]] = 1'b1;
        end
    end

    assign vLine = vCnt;    // Unflipped, for STATUS.

    // ************************************************************
    // Registered timing, one update per pixel.
    // ************************************************************

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hCnt     <= 9'd0;
            vCnt     <= `VT_V_FIRST;
            hPos     <= 8'd0;
            vPos     <= `VT_V_FIRST;
            hBlank   <= 1'b0;
            vBlank   <= 1'b0;
            hSync    <= 1'b0;
            vSync    <= 1'b0;
            busPhase <= 6'd0;
        end else if (pxlCen) begin
            hCnt     <= nextH;
            vCnt     <= nextV;
            hBlank   <= (nextH > `VT_ACTIVE_LAST);     // 256 to 383.
            vBlank   <= (nextV >= `VT_VBL_START);
            hSync    <= (nextH == `VT_HS_POS);         // Single pixel.
            vSync    <= (nextV == `VT_VS_LINE);        // Whole line.
            busPhase <= phaseNext;
            // Flip only mirrors the position, timing is unchanged.
            hPos     <= nextH[7:0] ^ {8{flip}};
            vPos     <= nextV ^ {8{flip}};
        end
    end

endmodule

`default_nettype wire

// File: logic/pixelCenGen.sv
`default_nettype none

// Pixel clock enable. One pulse every pixDiv+1 clocks.
module pixelCenGen (
    input  wire logic       clk,
    input  wire logic       rstN,
    input  wire logic       enable,
    input  wire logic [3:0] pixDiv,
    output logic            pxlCen
);

    logic [3:0] cnt;        // Clocks left until next pulse.
    logic [3:0] divReg;     // Divider seen last cycle.

    // Pulse on the zero count only.
    assign pxlCen = enable && (cnt == 4'd0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt    <= 4'd0;
            divReg <= 4'd0;
        end else begin
            divReg <= pixDiv;
            if (!enable) begin
                cnt <= 4'd0;                // Stopped, first pulse right on enable.
            end else if (pixDiv != divReg) begin
                cnt <= pixDiv;              // New ratio, restart the period.
            end else if (cnt == 4'd0) begin
                cnt <= pixDiv;              // Reload.
            end else begin
                cnt <= cnt - 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/vtPkg.sv
`default_nettype none

package vtPkg;

    // Test pattern selection, CTRL bits 3:2.
    typedef enum logic [1:0] {
        PatBars  = 2'd0,    // Eight colour bars.
        PatGrid  = 2'd1,    // White 16 pixel grid.
        PatRamp  = 2'd2,    // Red/green gradient.
        PatBlack = 2'd3     // Screen off.
    } patternMode;

    // Decoded APB register.
    typedef enum logic [1:0] {
        RegCtrl   = 2'd0,
        RegStatus = 2'd1,
        RegIrq    = 2'd2,
        RegNone   = 2'd3    // Unmapped, reads zero.
    } regIndex;

endpackage

`default_nettype wire

// File: logic/vtConsts.svh
`ifndef VT_CONSTS_SVH
`define VT_CONSTS_SVH

// ************************************************************
// Horizontal timing, in pixel counts.
// ************************************************************

// Last count of a line, 384 pixels in all.
`define VT_LINE_LAST    9'd383

// Last visible pixel. Blanking follows.
`define VT_ACTIVE_LAST  9'd255

// Sync pulse sits mid blanking.
`define VT_HS_POS       9'd319

// ************************************************************
// Vertical timing, in lines.
// ************************************************************

// Frame runs 0x08 to 0xFF, 248 lines.
`define VT_V_FIRST      8'h08
`define VT_V_LAST       8'hFF

// First blanked line, 16 lines of VBL.
`define VT_VBL_START    8'hF0

// VS covers this whole line.
`define VT_VS_LINE      8'hF8

// ************************************************************
// APB register map, byte addresses.
// ************************************************************

`define VT_ADDR_CTRL    12'h000   // Control, read/write.
`define VT_ADDR_STATUS  12'h004   // Line and blank, read only.
`define VT_ADDR_IRQ     12'h008   // Pending flag, write 1 clears.

`endif
